// ==== Makefile ====
# Verilator flow for the SPI flash reader
TB_TOP := tb_spi_flash_reader

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module spi_flash_reader
	verilator --lint-only --timing -f filelist.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TB_TOP) -o $(TB_TOP)
	./obj_dir/$(TB_TOP)

clean:
	rm -rf obj_dir

// ==== dv/spi_flash_model.sv ====
////////////////////
// Behavioral SPI NOR flash, read command 0x03 only
// Byte at A holds the low byte of A*7+3, the stream wraps at 24 bits
// Reports each word it starts, for the testbench checks
////////////////////
`timescale 1ns/1ps

module spi_flash_model (
	input  logic        i_cs_n,
	input  logic        i_sck,
	input  logic        i_mosi,
	output logic        o_miso,
	// Steps once per word begun, first word or continued
	output int          o_word_count,
	output logic        o_chained,
	output logic [7:0]  o_cmd,
	output logic [23:0] o_addr
);

	// SCK rising edges since chip select fell
	int          bits = 0;
	int          words = 0;
	int          data_bit;
	logic [31:0] hdr = '0;
	logic [7:0]  cur_byte;
	logic        miso_q = 1'b0;
	logic        chained_q = 1'b0;
	logic [23:0] word_addr_q = '0;

	assign o_miso       = miso_q && !i_cs_n;
	assign o_word_count = words;
	assign o_chained    = chained_q;
	assign o_cmd        = hdr[31:24];
	assign o_addr       = word_addr_q;

	// Memory content rule
	function automatic logic [7:0] byte_at(input logic [23:0] a);
		logic [31:0] v;
		v = 32'(a) * 32'd7 + 32'd3;
		return v[7:0];
	endfunction

	// MOSI taken on rising SCK, a rising chip select ends the transfer
	always @(posedge i_sck or posedge i_cs_n)
	begin
		if (i_cs_n)
			bits = 0;
		else
		begin
			// Command then byte address, top bit first
			if (bits < 32)
				hdr = {hdr[30:0], i_mosi};
			if (bits == 31)
			begin
				chained_q   = 1'b0;
				word_addr_q = hdr[23:0];
				words       = words + 1;
			end
			else if ((bits >= 64) && ((bits % 32) == 0))
			begin
				// First bit of a word on the same chip select
				chained_q   = 1'b1;
				word_addr_q = hdr[23:0] + 24'((bits - 32) / 8);
				words       = words + 1;
			end
			bits = bits + 1;
		end
	end

	// Next data bit goes out while SCK is low, auto-increment per byte
	always @(negedge i_sck)
	begin
		if (!i_cs_n && (bits >= 32))
		begin
			data_bit = bits - 32;
			cur_byte = byte_at(hdr[23:0] + 24'(data_bit / 8));
			miso_q   = cur_byte[7 - (data_bit % 8)];
		end
	end

endmodule

// ==== dv/tb_spi_flash_reader.sv ====
////////////////////
// Testbench for spi_flash_reader against a behavioral flash
// Random stimulus from a 16-bit Galois LFSR, seed 11
// Phases random, steady sequential, response stall, random again
// Stops at the first error
////////////////////
`timescale 1ns/1ps

module tb_spi_flash_reader;

	localparam int ADDR_W    = 22;
	localparam int NUM_REQ   = 300;
	localparam int WAIT_MAX  = 100000;
	localparam int STALL_LEN = 400;
	// Longer than one full transfer
	localparam int DRAIN_LEN = 300;
	// Flash read opcode
	localparam logic [7:0] EXP_CMD = 8'h03;

	logic                       clk;
	logic                       reset;
	logic                       req_valid;
	logic [ADDR_W-1:0]          req_addr;
	logic                       req_ready;
	logic                       rsp_ready;
	logic                       rsp_valid;
	flash_bus_pkg::data_word_t  rsp_data;
	logic                       cs_n;
	logic                       sck;
	logic                       mosi;
	logic                       miso;
	// Flash model report
	int                         flash_words;
	logic                       flash_chained;
	logic [7:0]                 flash_cmd;
	flash_bus_pkg::flash_addr_t flash_addr;

	logic [15:0]                lfsr_q = 16'd11;
	logic [31:0]                draw;
	// Reference queues, one for flash reads, one for responses
	logic [ADDR_W-1:0]          xfer_q [$];
	logic [ADDR_W-1:0]          rsp_q [$];
	flash_bus_pkg::flash_addr_t exp_addr;
	int                         accepted = 0;
	int                         responses = 0;
	int                         seen_words = 0;
	int                         chain_words = 0;
	logic                       req_taken = 1'b0;
	// Stimulus modes, changed on the falling edge
	logic                       go = 1'b0;
	logic                       steady = 1'b0;
	logic                       stall = 1'b0;

	spi_flash_reader #(.ADDR_W(ADDR_W)) i_dut (
		.i_clk       (clk),
		.i_reset     (reset),
		.i_req_valid (req_valid),
		.i_req_addr  (req_addr),
		.o_req_ready (req_ready),
		.i_rsp_ready (rsp_ready),
		.o_rsp_valid (rsp_valid),
		.o_rsp_data  (rsp_data),
		.o_spi_cs_n  (cs_n),
		.o_spi_sck   (sck),
		.o_spi_mosi  (mosi),
		.i_spi_miso  (miso)
	);

	spi_flash_model u_flash (
		.i_cs_n       (cs_n),
		.i_sck        (sck),
		.i_mosi       (mosi),
		.o_miso       (miso),
		.o_word_count (flash_words),
		.o_chained    (flash_chained),
		.o_cmd        (flash_cmd),
		.o_addr       (flash_addr)
	);

	// 8 ns clock
	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	////////////////////
	// Helpers
	////////////////////

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	// Four flash bytes of a word, lowest address in the top byte
	function automatic flash_bus_pkg::data_word_t pattern_word(input logic [ADDR_W-1:0] w);
		flash_bus_pkg::data_word_t v;
		logic [31:0]               a;
		int                        i;
		v = '0;
		for (i = 0; i < 4; i++)
		begin
			a = 32'({w, 2'b00}) + 32'(i);
			a = a * 32'd7 + 32'd3;
			v = {v[23:0], a[7:0]};
		end
		return v;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input flash_bus_pkg::data_word_t got,
		input flash_bus_pkg::data_word_t exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_cmd(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_addr(input flash_bus_pkg::flash_addr_t got,
		input flash_bus_pkg::flash_addr_t exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("mismatch at %0t: %s got %b expected %b",
				$time, what, got, exp));
	endtask

	////////////////////
	// Waits, each bounded
	////////////////////
	task automatic wait_accepted(input int n);
		int t;
		t = 0;
		while ((accepted < n) && (t < WAIT_MAX))
		begin
			@(negedge clk);
			t++;
		end
		if (accepted < n)
			stop_on_error("timeout, requests were not accepted");
	endtask

	task automatic wait_responses(input int n);
		int t;
		t = 0;
		while ((responses < n) && (t < WAIT_MAX))
		begin
			@(negedge clk);
			t++;
		end
		if (responses < n)
			stop_on_error("timeout, responses did not arrive");
	endtask

	task automatic wait_req_ready();
		int t;
		t = 0;
		while (!req_ready && (t < WAIT_MAX))
		begin
			@(negedge clk);
			t++;
		end
		if (!req_ready)
			stop_on_error("timeout, request ready stayed low after the stall");
	endtask

	////////////////////
	// Stimulus, 1 ns after the rising edge
	////////////////////
	always @(posedge clk)
	begin
		#1;
		if (go)
		begin
			// Address holds until the handshake
			if (req_taken || !req_valid)
			begin
				draw_bits(1, draw);
				req_valid = (accepted < NUM_REQ) && (steady || draw[0]);
				if (req_valid)
				begin
					draw_bits(1, draw);
					if (steady || draw[0])
						req_addr = req_addr + ADDR_W'(1);
					else
					begin
						draw_bits(ADDR_W, draw);
						req_addr = draw[ADDR_W-1:0];
					end
				end
			end
			draw_bits(1, draw);
			rsp_ready = !stall && (steady || draw[0]);
		end
	end

	////////////////////
	// Monitor, mid cycle where everything is stable
	////////////////////
	// Handshakes seen here complete at the next rising edge
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (sck && cs_n)
				stop_on_error("SCK went high with chip select high");
			req_taken = req_valid && req_ready;
			if (req_taken)
			begin
				xfer_q.push_back(req_addr);
				rsp_q.push_back(req_addr);
				accepted++;
			end
			if (rsp_valid && rsp_ready)
			begin
				if (rsp_q.size() == 0)
					stop_on_error("response arrived with no request outstanding");
				else
				begin
					check_word(rsp_data, pattern_word(rsp_q.pop_front()), "response word");
					responses++;
				end
			end
			// A new word began in the flash
			if (flash_words != seen_words)
			begin
				seen_words = flash_words;
				if (xfer_q.size() == 0)
					stop_on_error("flash read a word that was never requested");
				else
				begin
					exp_addr = {xfer_q.pop_front(), 2'b00};
					if (flash_chained)
						chain_words++;
					else
						check_cmd(flash_cmd, EXP_CMD, "flash command");
					check_addr(flash_addr, exp_addr, "flash byte address");
				end
			end
		end
	end

	////////////////////
	// Test sequence
	////////////////////
	initial
	begin
		reset     = 1'b1;
		req_valid = 1'b0;
		req_addr  = '0;
		rsp_ready = 1'b0;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		check_flag(cs_n, 1'b1, "chip select after reset");
		check_flag(sck, 1'b0, "SCK after reset");
		check_flag(rsp_valid, 1'b0, "response valid after reset");
		check_flag(req_ready, 1'b1, "request ready after reset");
		go = 1'b1;
		wait_accepted(100);
		// Back to back sequential words, ready held high
		steady = 1'b1;
		wait_accepted(160);
		steady = 1'b0;
		// Long response stall fills both slots and the holding register
		stall = 1'b1;
		repeat (STALL_LEN) @(negedge clk);
		check_flag(req_ready, 1'b0, "request ready during the stall");
		stall = 1'b0;
		wait_req_ready();
		wait_responses(NUM_REQ);
		// Quiet period, a duplicated word would still come out here
		repeat (DRAIN_LEN) @(negedge clk);
		if (chain_words == 0)
			stop_on_error("flash never saw a continued transfer");
		else if (rsp_valid)
			stop_on_error("extra response word after the last request");
		else
		begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

// ==== filelist.f ====
hdl/flash_spi_pkg.sv
hdl/flash_bus_pkg.sv
hdl/read_request_stage.sv
hdl/spi_sequencer.sv
hdl/read_response_stage.sv
hdl/spi_flash_reader.sv
dv/spi_flash_model.sv
dv/tb_spi_flash_reader.sv

// ==== hdl/flash_bus_pkg.sv ====
////////////////////
// Requester side types of the flash reader
// Words are 32 bits, first flash byte in the top bits
////////////////////
package flash_bus_pkg;

	// One word as returned on the response port
	// Byte at the lowest flash address sits in [31:24]
	typedef logic [31:0] data_word_t;

	// Byte address as shifted out to the flash
	// Word address in the upper bits, two zero bits at the bottom
	typedef logic [23:0] flash_addr_t;

	////////////////////
	// Response buffering
	////////////////////
	// Words that may be reserved or held at once
	// Also bounds how many starts can run ahead of the requester
	// Kept a power of two so the buffer pointers wrap on their own
	localparam int RSP_SLOTS = 2;

endpackage

// ==== hdl/flash_spi_pkg.sv ====
////////////////////
// SPI NOR flash read protocol, opcode 0x03 only
// Phase lengths are in SPI bits, one bit per two system clocks
////////////////////
package flash_spi_pkg;

	// Plain read opcode, no dummy cycles
	localparam logic [7:0] READ_CMD = 8'h03;

	// Transfer phase lengths in bits
	localparam int CMD_BITS  = 8;
	localparam int ADDR_BITS = 24;
	localparam int DATA_BITS = 32;

	// Bits still to go in the open transfer
	// 7 bits covers the 64-bit command + address + data transfer
	typedef logic [6:0] bit_count_t;

	////////////////////
	// Sequencer states
	////////////////////
	// IDLE  chip select high, waiting for a start
	// SHIFT chip select low, SCK running
	// HOLD  one cycle of chip select high before the next start
	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		HOLD
	} seq_state_e;

endpackage

// ==== hdl/read_request_stage.sv ====
////////////////////
// Request side holding register of the flash reader
// One request held, address must be stable while valid is high
// Sequential detect compares against the last forwarded address + 1
////////////////////
`timescale 1ns/1ps

module read_request_stage #(
	parameter int ADDR_W = 22
) (
	input  logic              i_clk,
	input  logic              i_reset,
	// Requester port
	input  logic              i_req_valid,
	input  logic [ADDR_W-1:0] i_req_addr,
	output logic              o_req_ready,
	// Start channel toward the sequencer
	input  logic              i_start_ready,
	input  logic              i_chain_open,
	output logic              o_start_valid,
	output logic [ADDR_W-1:0] o_start_addr,
	output logic              o_start_chain
);

	logic              hold_valid_q;
	logic [ADDR_W-1:0] hold_addr_q;
	// Address that would continue the current flash stream
	logic [ADDR_W-1:0] next_addr_q;
	logic              forward;

	////////////////////
	// Handshakes
	////////////////////

	// Held request leaves this cycle
	assign forward = hold_valid_q && i_start_ready;

	// Accept when empty, or when the held entry is forwarded now
	assign o_req_ready = !hold_valid_q || i_start_ready;

	assign o_start_valid = hold_valid_q;
	assign o_start_addr  = hold_addr_q;

	// Continue only if chip select is still low at the last data bit
	// and the held word directly follows the one being read
	assign o_start_chain = i_chain_open && (hold_addr_q == next_addr_q);

	////////////////////
	// Holding register
	////////////////////

	// Valid flag is the only control state here
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			hold_valid_q <= 1'b0;
		else if (o_req_ready)
			hold_valid_q <= i_req_valid;
	end

	// Payload loads with the accept
	always_ff @(posedge i_clk)
	begin
		if (o_req_ready && i_req_valid)
			hold_addr_q <= i_req_addr;
	end

	// Track the word after the one just sent to the sequencer
	// Compared only while a transfer is open
	always_ff @(posedge i_clk)
	begin
		if (forward)
			next_addr_q <= hold_addr_q + 1'b1;
	end

endmodule

// ==== hdl/read_response_stage.sv ====
////////////////////
// MISO deserializer and response buffer
// A slot is reserved at each word start, freed by the response pop
// Words leave in the order their transfers started
////////////////////
`timescale 1ns/1ps

module read_response_stage (
	input  logic                     i_clk,
	input  logic                     i_reset,
	// Strobes from the sequencer
	input  logic                     i_word_start,
	input  logic                     i_bit_sample,
	input  logic                     i_word_done,
	input  logic                     i_spi_miso,
	output logic                     o_slot_avail,
	// Response port
	input  logic                     i_rsp_ready,
	output logic                     o_rsp_valid,
	output flash_bus_pkg::data_word_t o_rsp_data
);

	localparam int PTR_W  = $clog2(flash_bus_pkg::RSP_SLOTS);
	localparam int CNT_W  = $clog2(flash_bus_pkg::RSP_SLOTS + 1);
	localparam int WORD_W = $bits(flash_bus_pkg::data_word_t);

	flash_bus_pkg::data_word_t shift_q;
	flash_bus_pkg::data_word_t buf_q [flash_bus_pkg::RSP_SLOTS];
	flash_bus_pkg::data_word_t word_in;
	logic [PTR_W-1:0]          wr_ptr_q;
	logic [PTR_W-1:0]          rd_ptr_q;
	// Words sitting in the buffer
	logic [CNT_W-1:0]          fill_q;
	// Words started but not yet popped, buffered ones included
	logic [CNT_W-1:0]          resv_q;
	logic                      pop;

	// Shifter value including the bit sampled this cycle
	assign word_in = {shift_q[WORD_W-2:0], i_spi_miso};

	assign pop          = o_rsp_valid && i_rsp_ready;
	assign o_rsp_valid  = (fill_q != '0);
	assign o_rsp_data   = buf_q[rd_ptr_q];
	assign o_slot_avail = (resv_q < CNT_W'(flash_bus_pkg::RSP_SLOTS));

	////////////////////
	// Data path
	////////////////////

	// Top bit first, so the first byte ends up in [31:24]
	always_ff @(posedge i_clk)
	begin
		if (i_bit_sample)
			shift_q <= word_in;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_word_done)
			buf_q[wr_ptr_q] <= word_in;
	end

	////////////////////
	// Pointers and counts
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			fill_q   <= '0;
			resv_q   <= '0;
		end
		else
		begin
			if (i_word_done)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			// Push and pop together leave the fill unchanged
			case ({i_word_done, pop})
			2'b10:   fill_q <= fill_q + 1'b1;
			2'b01:   fill_q <= fill_q - 1'b1;
			default: fill_q <= fill_q;
			endcase
			case ({i_word_start, pop})
			2'b10:   resv_q <= resv_q + 1'b1;
			2'b01:   resv_q <= resv_q - 1'b1;
			default: resv_q <= resv_q;
			endcase
		end
	end

endmodule

// ==== hdl/spi_flash_reader.sv ====
////////////////////
// Read-only SPI NOR flash controller, command 0x03
// ADDR_W is the word address width, 22 at most
// Sequential words share one chip select, up to two words in flight
////////////////////
`timescale 1ns/1ps

module spi_flash_reader #(
	parameter int ADDR_W = 22
) (
	input  logic                      i_clk,
	input  logic                      i_reset,
	// Request port
	input  logic                      i_req_valid,
	input  logic [ADDR_W-1:0]         i_req_addr,
	output logic                      o_req_ready,
	// Response port
	input  logic                      i_rsp_ready,
	output logic                      o_rsp_valid,
	output flash_bus_pkg::data_word_t o_rsp_data,
	// Flash pins
	output logic                      o_spi_cs_n,
	output logic                      o_spi_sck,
	output logic                      o_spi_mosi,
	input  logic                      i_spi_miso
);

	// Start channel
	logic              start_valid;
	logic              start_ready;
	logic [ADDR_W-1:0] start_addr;
	logic              start_chain;
	logic              chain_open;
	// Sequencer to response stage
	logic              word_start;
	logic              bit_sample;
	logic              word_done;
	logic              slot_avail;

	read_request_stage #(.ADDR_W(ADDR_W)) u_req (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_req_valid   (i_req_valid),
		.i_req_addr    (i_req_addr),
		.o_req_ready   (o_req_ready),
		.i_start_ready (start_ready),
		.i_chain_open  (chain_open),
		.o_start_valid (start_valid),
		.o_start_addr  (start_addr),
		.o_start_chain (start_chain)
	);

	spi_sequencer #(.ADDR_W(ADDR_W)) u_seq (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_start_valid (start_valid),
		.i_start_addr  (start_addr),
		.i_start_chain (start_chain),
		.o_start_ready (start_ready),
		.o_chain_open  (chain_open),
		.i_slot_avail  (slot_avail),
		.o_word_start  (word_start),
		.o_bit_sample  (bit_sample),
		.o_word_done   (word_done),
		.o_spi_cs_n    (o_spi_cs_n),
		.o_spi_sck     (o_spi_sck),
		.o_spi_mosi    (o_spi_mosi)
	);

	read_response_stage u_rsp (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_word_start (word_start),
		.i_bit_sample (bit_sample),
		.i_word_done  (word_done),
		.i_spi_miso   (i_spi_miso),
		.o_slot_avail (slot_avail),
		.i_rsp_ready  (i_rsp_ready),
		.o_rsp_valid  (o_rsp_valid),
		.o_rsp_data   (o_rsp_data)
	);

endmodule

// ==== hdl/spi_sequencer.sv ====
////////////////////
// SPI bit sequencer for the 0x03 flash read
// SCK runs at half i_clk, low cycle then high cycle per bit
// MISO sampled at the SCK rising edge, MOSI moves while SCK low
////////////////////
`timescale 1ns/1ps

module spi_sequencer #(
	parameter int ADDR_W = 22
) (
	input  logic              i_clk,
	input  logic              i_reset,
	// Start channel
	input  logic              i_start_valid,
	input  logic [ADDR_W-1:0] i_start_addr,
	input  logic              i_start_chain,
	output logic              o_start_ready,
	output logic              o_chain_open,
	// Response stage strobes
	input  logic              i_slot_avail,
	output logic              o_word_start,
	output logic              o_bit_sample,
	output logic              o_word_done,
	// Flash pins
	output logic              o_spi_cs_n,
	output logic              o_spi_sck,
	output logic              o_spi_mosi
);

	// Command and address go out of one shift register
	localparam int TX_BITS = flash_spi_pkg::CMD_BITS + flash_spi_pkg::ADDR_BITS;

	// Bit counts loaded at a start
	localparam flash_spi_pkg::bit_count_t NEW_BITS =
		flash_spi_pkg::bit_count_t'(TX_BITS + flash_spi_pkg::DATA_BITS);
	localparam flash_spi_pkg::bit_count_t CHAIN_BITS =
		flash_spi_pkg::bit_count_t'(flash_spi_pkg::DATA_BITS);

	flash_spi_pkg::seq_state_e  state_q;
	flash_spi_pkg::bit_count_t  bit_cnt_q;
	// Doubles as the SCK pin, high only in the second half of a bit
	logic                       sck_q;
	logic [TX_BITS-1:0]         tx_q;
	flash_bus_pkg::flash_addr_t start_byte_addr;
	logic                       in_data;
	logic                       last_bit;
	logic                       start_fire;

	////////////////////
	// Decode
	////////////////////

	// Word address to byte address, zero extended to 24 bits
	assign start_byte_addr = flash_bus_pkg::flash_addr_t'({i_start_addr, 2'b00});

	assign in_data  = (state_q == flash_spi_pkg::SHIFT) && (bit_cnt_q <= CHAIN_BITS);
	assign last_bit = (state_q == flash_spi_pkg::SHIFT) && (bit_cnt_q == 7'd1);

	// Second half of the last data bit, chip select still low
	assign o_chain_open = last_bit && sck_q;

	// Idle takes anything, an open transfer only takes a continuation
	// No start at all without a free response slot
	assign o_start_ready = i_slot_avail &&
		((state_q == flash_spi_pkg::IDLE) || (o_chain_open && i_start_chain));
	assign start_fire    = i_start_valid && o_start_ready;
	assign o_word_start  = start_fire;

	// Strobe in the SCK low cycle, so the sample lands on the rising edge
	assign o_bit_sample = in_data && !sck_q;
	assign o_word_done  = last_bit && !sck_q;

	assign o_spi_sck  = sck_q;
	// Quiet while deselected
	assign o_spi_mosi = tx_q[TX_BITS-1] && !o_spi_cs_n;

	////////////////////
	// Control FSM
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state_q    <= flash_spi_pkg::IDLE;
			sck_q      <= 1'b0;
			o_spi_cs_n <= 1'b1;
			bit_cnt_q  <= '0;
		end
		else
		begin
			case (state_q)
			flash_spi_pkg::IDLE:
				if (start_fire)
				begin
					state_q    <= flash_spi_pkg::SHIFT;
					o_spi_cs_n <= 1'b0;
					sck_q      <= 1'b0;
					bit_cnt_q  <= i_start_chain ? CHAIN_BITS : NEW_BITS;
				end
			flash_spi_pkg::SHIFT:
				if (!sck_q)
					sck_q <= 1'b1;
				else
				begin
					// Bit ends here, SCK falls
					sck_q <= 1'b0;
					if (!last_bit)
						bit_cnt_q <= bit_cnt_q - 1'b1;
					else if (start_fire)
						bit_cnt_q <= CHAIN_BITS;
					else
					begin
						// Nobody continued, deselect the flash
						state_q    <= flash_spi_pkg::HOLD;
						o_spi_cs_n <= 1'b1;
					end
				end
			flash_spi_pkg::HOLD:
				state_q <= flash_spi_pkg::IDLE;
			default:
				state_q <= flash_spi_pkg::IDLE;
			endcase
		end
	end

	////////////////////
	// MOSI shifter
	////////////////////
	// Continuations send nothing, the register empties to zero
	// after command and address anyway
	always_ff @(posedge i_clk)
	begin
		if (start_fire)
			tx_q <= i_start_chain ? '0 : {flash_spi_pkg::READ_CMD, start_byte_addr};
		else if ((state_q == flash_spi_pkg::SHIFT) && sck_q)
			tx_q <= {tx_q[TX_BITS-2:0], 1'b0};
	end

endmodule
